// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module id_control_tb -Mdir obj_dir
	./obj_dir/Vid_control_tb | tee /dev/stderr | grep -x "test passed" > /dev/null

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module id_control_stage

clean:
	rm -rf obj_dir

// File: project.f
+incdir+verilog
+incdir+verification
verilog/rv_decode_pkg.sv
verilog/inst_class_decode.sv
verilog/ex_ctrl_gen.sv
verilog/reg_mem_ctrl_gen.sv
verilog/id_control_stage.sv
verification/id_control_tb.sv

// File: verification/id_control_vectors.svh
`ifndef ID_CONTROL_VECTORS_SVH
`define ID_CONTROL_VECTORS_SVH

// columns: fill, instruction template, id_ctrl, ex_ctrl, mem_ctrl
// id  = rs1 rs2 rd jbase jump branch lui _ gen_type _ comp_type
// ex  = word slt_s slt_u shift src_pc src_imm shnum _ shift_type _ arith auipc _ alu_op
// mem = read write _ load_type _ store_type
// fill set means rd, rs1 and rs2 get random register numbers
task automatic load_vectors();
    // register ALU: add sub sll slt sltu xor srl sra or and
    push_row(1'b1, 32'h00000033, 13'b1110000_000_000, 15'b0000100_000_10_011, 8'b00_000_000);
    push_row(1'b1, 32'h40000033, 13'b1110000_000_000, 15'b0000100_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h00001033, 13'b1110000_000_000, 15'b0001100_001_10_000, 8'b00_000_000);
    push_row(1'b1, 32'h00002033, 13'b1110000_000_000, 15'b0100100_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h00003033, 13'b1110000_000_000, 15'b0010100_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h00004033, 13'b1110000_000_000, 15'b0000100_000_10_101, 8'b00_000_000);
    push_row(1'b1, 32'h00005033, 13'b1110000_000_000, 15'b0001100_101_10_000, 8'b00_000_000);
    push_row(1'b1, 32'h40005033, 13'b1110000_000_000, 15'b0001100_100_10_000, 8'b00_000_000);
    push_row(1'b1, 32'h00006033, 13'b1110000_000_000, 15'b0000100_000_10_110, 8'b00_000_000);
    push_row(1'b1, 32'h00007033, 13'b1110000_000_000, 15'b0000100_000_10_111, 8'b00_000_000);
    // immediate ALU, last four are slli srli srai and srai with bit 25 set
    push_row(1'b1, 32'h7ff00013, 13'b1010000_110_000, 15'b0000110_000_10_011, 8'b00_000_000);
    push_row(1'b1, 32'hfff02013, 13'b1010000_110_000, 15'b0100110_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h00003013, 13'b1010000_110_000, 15'b0010110_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h00004013, 13'b1010000_110_000, 15'b0000110_000_10_101, 8'b00_000_000);
    push_row(1'b1, 32'h00006013, 13'b1010000_110_000, 15'b0000110_000_10_110, 8'b00_000_000);
    push_row(1'b1, 32'h00007013, 13'b1010000_110_000, 15'b0000110_000_10_111, 8'b00_000_000);
    push_row(1'b0, 32'h00311093, 13'b1010000_000_000, 15'b0001101_001_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h00515093, 13'b1010000_000_000, 15'b0001101_101_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h40715093, 13'b1010000_000_000, 15'b0001101_100_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h42115093, 13'b1010000_000_000, 15'b0001101_100_10_000, 8'b00_000_000);
    // word immediate: addiw slliw srliw sraiw, then sraiw with bit 25 set
    push_row(1'b1, 32'h0000001b, 13'b1010000_110_000, 15'b1000110_000_10_011, 8'b00_000_000);
    push_row(1'b0, 32'h0031109b, 13'b1010000_000_000, 15'b1001101_011_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h0051509b, 13'b1010000_000_000, 15'b1001101_111_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h4071509b, 13'b1010000_000_000, 15'b1001101_110_10_000, 8'b00_000_000);
    push_row(1'b0, 32'h4211509b, 13'b1010000_000_000, 15'b1001101_000_10_000, 8'b00_000_000);
    // word register: addw subw sllw srlw sraw
    push_row(1'b1, 32'h0000003b, 13'b1110000_000_000, 15'b1000100_000_10_011, 8'b00_000_000);
    push_row(1'b1, 32'h4000003b, 13'b1110000_000_000, 15'b1000100_000_10_100, 8'b00_000_000);
    push_row(1'b1, 32'h0000103b, 13'b1110000_000_000, 15'b1001100_011_10_000, 8'b00_000_000);
    push_row(1'b1, 32'h0000503b, 13'b1110000_000_000, 15'b1001100_111_10_000, 8'b00_000_000);
    push_row(1'b1, 32'h4000503b, 13'b1110000_000_000, 15'b1001100_110_10_000, 8'b00_000_000);
    // branches: beq bne blt bge bltu bgeu
    push_row(1'b1, 32'h00000063, 13'b1100010_111_010, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00001063, 13'b1100010_111_011, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00004063, 13'b1100010_111_100, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00005063, 13'b1100010_111_110, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00006063, 13'b1100010_111_101, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00007063, 13'b1100010_111_111, 15'b0000100_000_00_000, 8'b00_000_000);
    // jal jalr lui auipc
    push_row(1'b1, 32'h0000006f, 13'b0010100_101_000, 15'b0000100_000_00_011, 8'b00_000_000);
    push_row(1'b1, 32'h00000067, 13'b1011100_110_000, 15'b0000100_000_00_011, 8'b00_000_000);
    push_row(1'b1, 32'h00000037, 13'b0010001_100_000, 15'b0000100_000_00_000, 8'b00_000_000);
    push_row(1'b1, 32'h00000017, 13'b0010000_100_000, 15'b0000010_000_01_011, 8'b00_000_000);
    // loads: lb lh lw ld lbu lhu lwu
    push_row(1'b1, 32'h00000003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_001_000);
    push_row(1'b1, 32'h00001003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_010_000);
    push_row(1'b1, 32'h00002003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_011_000);
    push_row(1'b1, 32'h00003003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_100_000);
    push_row(1'b1, 32'h00004003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_101_000);
    push_row(1'b1, 32'h00005003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_110_000);
    push_row(1'b1, 32'h00006003, 13'b1010000_110_000, 15'b0000110_000_00_011, 8'b10_111_000);
    // stores: sb sh sw sd
    push_row(1'b1, 32'h00000023, 13'b1100000_011_000, 15'b0000110_000_00_011, 8'b01_000_100);
    push_row(1'b1, 32'h00001023, 13'b1100000_011_000, 15'b0000110_000_00_011, 8'b01_000_101);
    push_row(1'b1, 32'h00002023, 13'b1100000_011_000, 15'b0000110_000_00_011, 8'b01_000_110);
    push_row(1'b1, 32'h00003023, 13'b1100000_011_000, 15'b0000110_000_00_011, 8'b01_000_111);
    // unknown opcode, only alu_src_pc stays high
    push_row(1'b1, 32'h0000007f, 13'b0000000_000_000, 15'b0000100_000_00_000, 8'b00_000_000);
endtask

`endif

// File: verification/id_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defs.svh"

module id_control_tb
    import rv_decode_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int TIMEOUT_CYCLES = 10;
    // rd, rs1 and rs2 fields of the instruction word
    localparam logic [`RV_INST_W-1:0] REG_FIELD_MASK = 32'h01ff_8f80;

    typedef struct packed {
        logic                  fill;
        logic [`RV_INST_W-1:0] inst;
        id_ctrl_t              id;
        ex_ctrl_t              ex;
        mem_ctrl_t             mem;
    } vector_t;

    logic      clk;
    logic      arst_n_i;
    logic      inst_valid_i;
    rv_inst_u  inst_i;
    logic      valid_o;
    id_ctrl_t  id_ctrl_o;
    ex_ctrl_t  ex_ctrl_o;
    mem_ctrl_t mem_ctrl_o;

    vector_t   vectors[$];
    int        mismatch_count;
    int        failure_count;
    logic      timed_out;

    id_control_stage dut_i (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .valid_o      (valid_o),
        .id_ctrl_o    (id_ctrl_o),
        .ex_ctrl_o    (ex_ctrl_o),
        .mem_ctrl_o   (mem_ctrl_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    task automatic push_row(input logic fill, input logic [`RV_INST_W-1:0] inst,
                            input id_ctrl_t id, input ex_ctrl_t ex, input mem_ctrl_t mem);
        vector_t row;
        row.fill = fill;
        row.inst = inst;
        row.id   = id;
        row.ex   = ex;
        row.mem  = mem;
        vectors.push_back(row);
    endtask

    `include "id_control_vectors.svh"

    task automatic check_valid(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            $display("mismatch valid_o (%s): got %h expected %h", tag, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_id(input id_ctrl_t got, input id_ctrl_t exp, input string tag);
        if (got !== exp) begin
            $display("mismatch id_ctrl_o (%s): got %h expected %h", tag, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_ex(input ex_ctrl_t got, input ex_ctrl_t exp, input string tag);
        if (got !== exp) begin
            $display("mismatch ex_ctrl_o (%s): got %h expected %h", tag, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_mem(input mem_ctrl_t got, input mem_ctrl_t exp, input string tag);
        if (got !== exp) begin
            $display("mismatch mem_ctrl_o (%s): got %h expected %h", tag, got, exp);
            mismatch_count++;
        end
    endtask

    // polls on falling edges, outputs are settled there
    task automatic wait_for_valid(output int cycles);
        cycles = 0;
        while (valid_o !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (valid_o !== 1'b1) begin
            $display("valid_o never rose within %0d cycles", TIMEOUT_CYCLES);
            failure_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        int                    late;
        string                 tag;
        logic [`RV_INST_W-1:0] word;
        logic [`RV_INST_W-1:0] noise;

        void'($urandom(32'heb21_40af));
        mismatch_count = 0;
        failure_count  = 0;
        timed_out      = 1'b0;
        arst_n_i       = 1'b0;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        load_vectors();

        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_valid(valid_o, 1'b0, "after reset");
        check_id(id_ctrl_o, '0, "after reset");
        check_ex(ex_ctrl_o, '0, "after reset");
        check_mem(mem_ctrl_o, '0, "after reset");

        for (int i = 0; i < vectors.size(); i++) begin
            noise = $urandom();
            word  = vectors[i].inst;
            if (vectors[i].fill) begin
                word = (word & ~REG_FIELD_MASK) | (noise & REG_FIELD_MASK);
            end
            tag = $sformatf("row %0d inst %h", i, word);

            @(posedge clk);
            inst_valid_i <= 1'b1;
            inst_i       <= word;
            @(posedge clk);
            // next cycle carries junk with the strobe low
            inst_valid_i <= 1'b0;
            inst_i       <= $urandom();
            @(negedge clk);
            wait_for_valid(late);
            if (timed_out) begin
                break;
            end
            if (late != 0) begin
                $display("valid_o rose %0d cycles late for %s", late, tag);
                failure_count++;
            end
            check_id(id_ctrl_o, vectors[i].id, tag);
            check_ex(ex_ctrl_o, vectors[i].ex, tag);
            check_mem(mem_ctrl_o, vectors[i].mem, tag);

            // strobe dropped, controls must hold
            @(negedge clk);
            check_valid(valid_o, 1'b0, {tag, " hold"});
            check_id(id_ctrl_o, vectors[i].id, {tag, " hold"});
            check_ex(ex_ctrl_o, vectors[i].ex, {tag, " hold"});
            check_mem(mem_ctrl_o, vectors[i].mem, {tag, " hold"});
        end

        report_and_finish();
    end

endmodule

`default_nettype wire

// File: verilog/ex_ctrl_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ex_ctrl_gen
    import rv_decode_pkg::*;
(
    input  rv_inst_u    inst_i,
    input  inst_class_t class_i,
    output ex_ctrl_t    ex_ctrl_o
);

    funct3_t funct3;
    funct7_t funct7;
    logic    op_base;
    logic    op_alt;
    logic    opw_base;
    logic    opw_alt;
    logic    imm_base;
    logic    imm_alt;
    logic    immw_base;
    logic    immw_alt;
    logic    add_any;
    logic    sub_any;
    logic    slt_s;
    logic    slt_u;
    logic    xor_any;
    logic    or_any;
    logic    and_any;

    assign funct3 = inst_i.r.funct3;
    assign funct7 = inst_i.r.funct7;

    // legal funct7 for register forms and word shifts
    assign op_base   = class_i.op & (funct7 == 7'b0000000);
    assign op_alt    = class_i.op & (funct7 == 7'b0100000);
    assign opw_base  = class_i.op_w & (funct7 == 7'b0000000);
    assign opw_alt   = class_i.op_w & (funct7 == 7'b0100000);
    assign immw_base = class_i.op_imm_w & (funct7 == 7'b0000000);
    assign immw_alt  = class_i.op_imm_w & (funct7 == 7'b0100000);

    // 64-bit shamt owns bit 25, only imm[11:6] picks the shift
    assign imm_base = class_i.op_imm & (inst_i.i.imm[11:6] == 6'b000000);
    assign imm_alt  = class_i.op_imm & (inst_i.i.imm[11:6] == 6'b010000);

    assign add_any = (class_i.op_imm | class_i.op_imm_w | op_base | opw_base)
                     & (funct3 == 3'b000);
    assign sub_any = (op_alt | opw_alt) & (funct3 == 3'b000);
    assign slt_s   = (class_i.op_imm | op_base) & (funct3 == 3'b010);
    assign slt_u   = (class_i.op_imm | op_base) & (funct3 == 3'b011);
    assign xor_any = (class_i.op_imm | op_base) & (funct3 == 3'b100);
    assign or_any  = (class_i.op_imm | op_base) & (funct3 == 3'b110);
    assign and_any = (class_i.op_imm | op_base) & (funct3 == 3'b111);

    always_comb begin
        ex_ctrl_o = '0;
        ex_ctrl_o.inst_word     = class_i.op_imm_w | class_i.op_w;
        ex_ctrl_o.slt_s         = slt_s;
        ex_ctrl_o.slt_u         = slt_u;
        ex_ctrl_o.inst_shift    = class_i.shift;
        // operand a is the pc only for auipc
        ex_ctrl_o.alu_src_pc    = ~class_i.auipc;
        ex_ctrl_o.alu_src_imm   = class_i.auipc | class_i.load | class_i.store
                                  | ((class_i.op_imm | class_i.op_imm_w) & ~class_i.shift);
        ex_ctrl_o.shift_num_src = class_i.shift & (class_i.op_imm | class_i.op_imm_w);
        ex_ctrl_o.arith_logic   = class_i.op_imm | class_i.op_imm_w | class_i.op | class_i.op_w;
        ex_ctrl_o.inst_auipc    = class_i.auipc;

        if (add_any | class_i.auipc | class_i.jal | class_i.jalr
            | class_i.load | class_i.store) begin
            ex_ctrl_o.alu_op = ALU_ADD;
        end else if (sub_any | slt_s | slt_u) begin
            // compare goes through the subtractor
            ex_ctrl_o.alu_op = ALU_SUB;
        end else if (xor_any) begin
            ex_ctrl_o.alu_op = ALU_XOR;
        end else if (or_any) begin
            ex_ctrl_o.alu_op = ALU_OR;
        end else if (and_any) begin
            ex_ctrl_o.alu_op = ALU_AND;
        end

        if (funct3 == 3'b001) begin
            if (imm_base | op_base) begin
                ex_ctrl_o.shift_type = SHIFT_SLL;
            end else if (immw_base | opw_base) begin
                ex_ctrl_o.shift_type = SHIFT_SLLW;
            end
        end else if (funct3 == 3'b101) begin
            if (imm_base | op_base) begin
                ex_ctrl_o.shift_type = SHIFT_SRL;
            end else if (imm_alt | op_alt) begin
                ex_ctrl_o.shift_type = SHIFT_SRA;
            end else if (immw_base | opw_base) begin
                ex_ctrl_o.shift_type = SHIFT_SRLW;
            end else if (immw_alt | opw_alt) begin
                ex_ctrl_o.shift_type = SHIFT_SRAW;
            end
        end
    end

    // shift flag comes from the class decoder, shift type from here
    always_comb begin
        shift_type_a: assert final ((ex_ctrl_o.shift_type == SHIFT_NONE)
                                    || ex_ctrl_o.inst_shift)
            else $error("shift type set on a non-shift instruction");
    end

endmodule

`default_nettype wire

// File: verilog/id_control_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_control_stage
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      inst_valid_i,
    input  rv_inst_u  inst_i,
    output logic      valid_o,
    output id_ctrl_t  id_ctrl_o,
    output ex_ctrl_t  ex_ctrl_o,
    output mem_ctrl_t mem_ctrl_o
);

    inst_class_t inst_class;
    id_ctrl_t    id_ctrl_d;
    ex_ctrl_t    ex_ctrl_d;
    mem_ctrl_t   mem_ctrl_d;

    inst_class_decode u_inst_class_decode (
        .inst_i  (inst_i),
        .class_o (inst_class)
    );

    ex_ctrl_gen u_ex_ctrl_gen (
        .inst_i    (inst_i),
        .class_i   (inst_class),
        .ex_ctrl_o (ex_ctrl_d)
    );

    reg_mem_ctrl_gen u_reg_mem_ctrl_gen (
        .inst_i     (inst_i),
        .class_i    (inst_class),
        .id_ctrl_o  (id_ctrl_d),
        .mem_ctrl_o (mem_ctrl_d)
    );

    // valid follows the strobe every cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= inst_valid_i;
        end
    end

    // controls load only on a valid instruction, otherwise hold
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ctrl_o  <= '0;
            ex_ctrl_o  <= '0;
            mem_ctrl_o <= '0;
        end else if (inst_valid_i) begin
            id_ctrl_o  <= id_ctrl_d;
            ex_ctrl_o  <= ex_ctrl_d;
            mem_ctrl_o <= mem_ctrl_d;
        end
    end

    // first edge after reset release still sees the cleared valid
    valid_after_reset_a: assert property (@(posedge clk) $rose(arst_n_i) |-> !valid_o)
        else $error("valid_o high in the cycle after reset release");

endmodule

`default_nettype wire

// File: verilog/inst_class_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defs.svh"

module inst_class_decode
    import rv_decode_pkg::*;
(
    input  rv_inst_u    inst_i,
    output inst_class_t class_o
);

    logic [`RV_OPCODE_W-1:0] opcode;

    assign opcode = inst_i.r.opcode;

    // one compare per class against the opcode macros
    always_comb begin
        class_o          = '0;
        class_o.lui      = (opcode == `RV_OPC_LUI);
        class_o.auipc    = (opcode == `RV_OPC_AUIPC);
        class_o.jal      = (opcode == `RV_OPC_JAL);
        class_o.jalr     = (opcode == `RV_OPC_JALR);
        class_o.branch   = (opcode == `RV_OPC_BRANCH);
        class_o.load     = (opcode == `RV_OPC_LOAD);
        class_o.store    = (opcode == `RV_OPC_STORE);
        class_o.op_imm   = (opcode == `RV_OPC_OP_IMM);
        class_o.op_imm_w = (opcode == `RV_OPC_OP_IMM_32);
        class_o.op       = (opcode == `RV_OPC_OP);
        class_o.op_w     = (opcode == `RV_OPC_OP_32);

        // shifts are funct3 x01 in any ALU class
        class_o.shift = (class_o.op_imm | class_o.op_imm_w | class_o.op | class_o.op_w)
                        & (inst_i.r.funct3[1:0] == 2'b01);
    end

    // class flags feed both generators and at most one may be set
    always_comb begin
        class_onehot_a: assert final ($onehot0({class_o.lui, class_o.auipc, class_o.jal,
                                                class_o.jalr, class_o.branch, class_o.load,
                                                class_o.store, class_o.op_imm,
                                                class_o.op_imm_w, class_o.op,
                                                class_o.op_w}))
            else $error("instruction class flags not one-hot");
    end

endmodule

`default_nettype wire

// File: verilog/reg_mem_ctrl_gen.sv
`timescale 1ns/1ps
`default_nettype none

module reg_mem_ctrl_gen
    import rv_decode_pkg::*;
(
    input  rv_inst_u    inst_i,
    input  inst_class_t class_i,
    output id_ctrl_t    id_ctrl_o,
    output mem_ctrl_t   mem_ctrl_o
);

    funct3_t funct3;
    logic    alu_any;
    logic    imm_alu;

    assign funct3  = inst_i.r.funct3;
    assign alu_any = class_i.op_imm | class_i.op_imm_w | class_i.op | class_i.op_w;
    // immediate ALU ops other than shifts use the i-type immediate
    assign imm_alu = (class_i.op_imm | class_i.op_imm_w) & ~class_i.shift;

    always_comb begin
        id_ctrl_o = '0;
        id_ctrl_o.rs1_en       = class_i.jalr | class_i.branch | class_i.load
                                 | class_i.store | alu_any;
        id_ctrl_o.rs2_en       = class_i.branch | class_i.store | class_i.op | class_i.op_w;
        id_ctrl_o.rd_en        = class_i.lui | class_i.auipc | class_i.jal | class_i.jalr
                                 | class_i.load | alu_any;
        id_ctrl_o.jump_base_pc = class_i.jalr;
        id_ctrl_o.inst_jump    = class_i.jal | class_i.jalr;
        id_ctrl_o.inst_branch  = class_i.branch;
        id_ctrl_o.inst_lui     = class_i.lui;

        if (class_i.store) begin
            id_ctrl_o.gen_type = GEN_STORE;
        end else if (class_i.lui | class_i.auipc) begin
            id_ctrl_o.gen_type = GEN_UPPER;
        end else if (class_i.jal) begin
            id_ctrl_o.gen_type = GEN_JAL;
        end else if (class_i.jalr | class_i.load | imm_alu) begin
            id_ctrl_o.gen_type = GEN_ITYPE;
        end else if (class_i.branch) begin
            id_ctrl_o.gen_type = GEN_BRANCH;
        end

        if (class_i.branch) begin
            case (funct3)
                3'b000:  id_ctrl_o.comp_type = COMP_BEQ;
                3'b001:  id_ctrl_o.comp_type = COMP_BNE;
                3'b100:  id_ctrl_o.comp_type = COMP_BLT;
                3'b101:  id_ctrl_o.comp_type = COMP_BGE;
                3'b110:  id_ctrl_o.comp_type = COMP_BLTU;
                3'b111:  id_ctrl_o.comp_type = COMP_BGEU;
                default: id_ctrl_o.comp_type = COMP_NONE;
            endcase
        end
    end

    always_comb begin
        mem_ctrl_o = '0;
        mem_ctrl_o.mem_read  = class_i.load;
        mem_ctrl_o.mem_write = class_i.store;

        if (class_i.load) begin
            // funct3 111 has no load
            case (funct3)
                3'b000:  mem_ctrl_o.load_type = LD_LB;
                3'b001:  mem_ctrl_o.load_type = LD_LH;
                3'b010:  mem_ctrl_o.load_type = LD_LW;
                3'b011:  mem_ctrl_o.load_type = LD_LD;
                3'b100:  mem_ctrl_o.load_type = LD_LBU;
                3'b101:  mem_ctrl_o.load_type = LD_LHU;
                3'b110:  mem_ctrl_o.load_type = LD_LWU;
                default: mem_ctrl_o.load_type = LD_NONE;
            endcase
        end

        if (class_i.store) begin
            case (funct3)
                3'b000:  mem_ctrl_o.store_type = ST_SB;
                3'b001:  mem_ctrl_o.store_type = ST_SH;
                3'b010:  mem_ctrl_o.store_type = ST_SW;
                3'b011:  mem_ctrl_o.store_type = ST_SD;
                default: mem_ctrl_o.store_type = ST_NONE;
            endcase
        end
    end

    // relies on the class decoder never flagging load and store together
    always_comb begin
        mem_rw_excl_a: assert final (!(mem_ctrl_o.mem_read && mem_ctrl_o.mem_write))
            else $error("memory read and write strobes both set");
    end

endmodule

`default_nettype wire

// File: verilog/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// instruction word and field widths
`define RV_INST_W       32
`define RV_OPCODE_W     7
`define RV_FUNCT3_W     3
`define RV_FUNCT7_W     7

// every encoded control field is this wide
`define RV_CTRL_W       3

// base opcodes kept by the decoder
`define RV_OPC_LUI          7'b0110111
`define RV_OPC_AUIPC        7'b0010111
`define RV_OPC_JAL          7'b1101111
`define RV_OPC_JALR         7'b1100111
`define RV_OPC_BRANCH       7'b1100011
`define RV_OPC_LOAD         7'b0000011
`define RV_OPC_STORE        7'b0100011

// ALU opcodes, immediate and register forms
`define RV_OPC_OP_IMM       7'b0010011
`define RV_OPC_OP_IMM_32    7'b0011011
`define RV_OPC_OP           7'b0110011
`define RV_OPC_OP_32        7'b0111011

`endif

// File: verilog/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_defs.svh"

package rv_decode_pkg;

    localparam int unsigned RV_REG_W = 5;
    // immediate fills what the i view leaves above rs1
    localparam int unsigned RV_IMM_W =
        `RV_INST_W - 2 * RV_REG_W - `RV_FUNCT3_W - `RV_OPCODE_W;

    typedef logic [`RV_FUNCT3_W-1:0] funct3_t;
    typedef logic [`RV_FUNCT7_W-1:0] funct7_t;

    typedef struct packed {
        funct7_t                 funct7;
        logic [RV_REG_W-1:0]     rs2;
        logic [RV_REG_W-1:0]     rs1;
        funct3_t                 funct3;
        logic [RV_REG_W-1:0]     rd;
        logic [`RV_OPCODE_W-1:0] opcode;
    } rv_inst_r_t;

    typedef struct packed {
        logic [RV_IMM_W-1:0]     imm;
        logic [RV_REG_W-1:0]     rs1;
        funct3_t                 funct3;
        logic [RV_REG_W-1:0]     rd;
        logic [`RV_OPCODE_W-1:0] opcode;
    } rv_inst_i_t;

    // same word, register view or immediate view
    typedef union packed {
        rv_inst_r_t r;
        rv_inst_i_t i;
    } rv_inst_u;

    typedef struct packed {
        logic lui;
        logic auipc;
        logic jal;
        logic jalr;
        logic branch;
        logic load;
        logic store;
        logic op_imm;
        logic op_imm_w;
        logic op;
        logic op_w;
        logic shift;
    } inst_class_t;

    typedef enum logic [`RV_CTRL_W-1:0] {
        GEN_NONE   = 3'd0,
        GEN_STORE  = 3'd3,
        GEN_UPPER  = 3'd4,
        GEN_JAL    = 3'd5,
        GEN_ITYPE  = 3'd6,
        GEN_BRANCH = 3'd7
    } gen_type_e;

    typedef enum logic [`RV_CTRL_W-1:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd3,
        ALU_SUB  = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_OR   = 3'd6,
        ALU_AND  = 3'd7
    } alu_op_e;

    typedef enum logic [`RV_CTRL_W-1:0] {
        COMP_NONE = 3'd0,
        COMP_BEQ  = 3'd2,
        COMP_BNE  = 3'd3,
        COMP_BLT  = 3'd4,
        COMP_BLTU = 3'd5,
        COMP_BGE  = 3'd6,
        COMP_BGEU = 3'd7
    } comp_type_e;

    typedef enum logic [`RV_CTRL_W-1:0] {
        SHIFT_NONE = 3'd0,
        SHIFT_SLL  = 3'd1,
        SHIFT_SLLW = 3'd3,
        SHIFT_SRA  = 3'd4,
        SHIFT_SRL  = 3'd5,
        SHIFT_SRAW = 3'd6,
        SHIFT_SRLW = 3'd7
    } shift_type_e;

    typedef enum logic [`RV_CTRL_W-1:0] {
        ST_NONE = 3'd0,
        ST_SB   = 3'd4,
        ST_SH   = 3'd5,
        ST_SW   = 3'd6,
        ST_SD   = 3'd7
    } store_type_e;

    typedef enum logic [`RV_CTRL_W-1:0] {
        LD_NONE = 3'd0,
        LD_LB   = 3'd1,
        LD_LH   = 3'd2,
        LD_LW   = 3'd3,
        LD_LD   = 3'd4,
        LD_LBU  = 3'd5,
        LD_LHU  = 3'd6,
        LD_LWU  = 3'd7
    } load_type_e;

    typedef struct packed {
        logic       rs1_en;
        logic       rs2_en;
        logic       rd_en;
        logic       jump_base_pc;
        logic       inst_jump;
        logic       inst_branch;
        logic       inst_lui;
        gen_type_e  gen_type;
        comp_type_e comp_type;
    } id_ctrl_t;

    typedef struct packed {
        logic        inst_word;
        logic        slt_s;
        logic        slt_u;
        logic        inst_shift;
        logic        alu_src_pc;
        logic        alu_src_imm;
        logic        shift_num_src;
        shift_type_e shift_type;
        logic        arith_logic;
        logic        inst_auipc;
        alu_op_e     alu_op;
    } ex_ctrl_t;

    typedef struct packed {
        logic        mem_read;
        logic        mem_write;
        load_type_e  load_type;
        store_type_e store_type;
    } mem_ctrl_t;

endpackage

`default_nettype wire
